//--- all.f
cpu_pkg.sv
word_ram.sv
cpu_control.sv
pc_unit.sv
reg_file.sv
cpu_alu.sv
cpu_top.sv
tb_cpu.sv

//--- cpu_alu.sv
// registered ALU: add, sub, signed slt and the rs+imm address add
// multiply keeps only the low 16 bits, split over two register stages
// result is valid one cycle after alu_go, product two cycles after

`default_nettype none
`timescale 1ns/10ps

module cpu_alu
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alu_go,
    input  opcode_e           opcode,
    input  logic              func,
    input  logic signed [4:0] imm,
    input  word_t             rs_data,
    input  word_t             rt_data,
    output word_t             alu_result,
    output word_t             product,
    output logic              regs_equal
);

    logic [DATA_W-1:0] a_u;
    logic [DATA_W-1:0] b_u;
    logic [DATA_W-1:0] pp_lo;
    logic [7:0]        pp_hi;
    logic              mult_s1;

    assign a_u        = rs_data;
    assign b_u        = rt_data;
    assign regs_equal = (rs_data == rt_data);

    always_ff @(posedge clk) begin
        if (alu_go) begin
            case (opcode)
                OP_RTYPE:  alu_result <= func ? rs_data + rt_data : rs_data - rt_data;
                OP_MULSLT: alu_result <= (rs_data < rt_data) ? word_t'(1) : word_t'(0);
                default:   alu_result <= rs_data + word_t'(imm);
            endcase
        end
    end

    // ########################################################################
    // two-stage multiply
    // ########################################################################
    // stage 1: partial products on the low and high byte of rt
    // two's complement low half is the same as the unsigned low half
    always_ff @(posedge clk) begin
        if (alu_go) begin
            pp_lo <= a_u * b_u[7:0];
            pp_hi <= a_u[7:0] * b_u[15:8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_s1 <= 1'b0;
        end else begin
            mult_s1 <= alu_go && (opcode == OP_MULSLT) && !func;
        end
    end

    // stage 2: recombine
    always_ff @(posedge clk) begin
        if (mult_s1) begin
            product <= pp_lo + {pp_hi, 8'h00};
        end
    end

endmodule

`default_nettype wire

//--- cpu_control.sv
// sequencing FSM of the multi-cycle core: fetch, decode, execute, write-back
// load port writes are honoured only in idle; start is ignored once running
// the core never halts, busy stays high until reset

`default_nettype none
`timescale 1ns/10ps

module cpu_control
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_valid,
    input  logic       load_to_data,
    input  logic       start,
    input  opcode_e    opcode,
    input  logic       func,
    output logic       busy,
    output logic       imem_load_we,
    output logic       dmem_load_we,
    output logic       ram_load_sel,
    output logic       dmem_core_we,
    output logic       ir_load,
    output logic       rf_read,
    output logic       alu_go,
    output logic       pc_step,
    output logic       pc_clear,
    output logic       rf_we,
    output logic [1:0] rf_we_src,
    output logic       retire_valid
);

    ctrl_state_e state;
    ctrl_state_e state_nx;
    logic [1:0]  mult_cnt;
    logic        mult_done;
    logic        is_mult;
    logic        is_mem_op;
    logic        writes_reg;

    assign is_mult    = (opcode == OP_MULSLT) && !func;
    assign is_mem_op  = (opcode == OP_LOAD) || (opcode == OP_STORE);
    assign writes_reg = (opcode == OP_RTYPE) || (opcode == OP_MULSLT) || (opcode == OP_LOAD);
    assign mult_done  = (mult_cnt == 2'(MULT_LAT - 2));

    // ########################################################################
    // state register and next state
    // ########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    // extra multiply cycles beyond the first MULT cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_cnt <= '0;
        end else if (state == ST_MULT) begin
            mult_cnt <= mult_cnt + 2'd1;
        end else begin
            mult_cnt <= '0;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nx = ST_FETCH;
                end
            end
            ST_FETCH:  state_nx = ST_DECODE;
            ST_DECODE: state_nx = ST_EXEC;
            ST_EXEC: begin
                if (is_mult) begin
                    state_nx = ST_MULT;
                end else if (is_mem_op) begin
                    state_nx = ST_MEM;
                end else begin
                    state_nx = ST_WB;
                end
            end
            ST_MULT: begin
                if (mult_done) begin
                    state_nx = ST_WB;
                end
            end
            ST_MEM:  state_nx = ST_WB;
            ST_WB:   state_nx = ST_FETCH;
            default: state_nx = ST_IDLE;
        endcase
    end

    // ########################################################################
    // strobes and selects
    // ########################################################################
    assign busy         = (state != ST_IDLE);
    assign ram_load_sel = (state == ST_IDLE);
    assign imem_load_we = ram_load_sel && load_valid && !load_to_data;
    assign dmem_load_we = ram_load_sel && load_valid && load_to_data;
    assign dmem_core_we = (state == ST_MEM) && (opcode == OP_STORE);

    assign ir_load  = (state == ST_FETCH);
    assign rf_read  = (state == ST_DECODE);
    assign alu_go   = (state == ST_EXEC);
    assign pc_clear = (state == ST_IDLE) && start;

    // pc moves on the last cycle before WB so retire_pc already shows the next pc
    assign pc_step = (state != ST_WB) && (state_nx == ST_WB);

    assign rf_we        = (state == ST_WB) && writes_reg;
    assign rf_we_src    = is_mult ? WB_SRC_MULT :
                          (opcode == OP_LOAD) ? WB_SRC_MEM : WB_SRC_ALU;
    assign retire_valid = (state == ST_WB);

endmodule

`default_nettype wire

//--- cpu_pkg.sv
// shared widths, opcodes, instruction layout and FSM encoding for the 16-bit core
// instruction and data memories are 128 words each, so every address wraps mod 128
// the immediate field overlaps rd and func and is read through the union views

`default_nettype none

package cpu_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_COUNT = 16;
    localparam int MEM_DEPTH = 128;
    localparam int PC_W      = 7;
    localparam int MULT_LAT  = 2;

    // write-back source select
    localparam logic [1:0] WB_SRC_ALU  = 2'd0;
    localparam logic [1:0] WB_SRC_MULT = 2'd1;
    localparam logic [1:0] WB_SRC_MEM  = 2'd2;

    typedef logic signed [DATA_W-1:0] word_t;
    typedef logic [3:0]               reg_idx_t;
    typedef logic [PC_W-1:0]          mem_addr_t;

    typedef enum logic [2:0] {
        OP_RTYPE  = 3'd0,
        OP_MULSLT = 3'd1,
        OP_STORE  = 3'd2,
        OP_LOAD   = 3'd3,
        OP_JUMP   = 3'd4,
        OP_BEQ    = 3'd5
    } opcode_e;

    // three views of one instruction word
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     func;
    } instr_r_t;

    typedef struct packed {
        opcode_e           opcode;
        reg_idx_t          rs;
        reg_idx_t          rt;
        logic signed [4:0] imm;
    } instr_i_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [12:0] addr;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MULT,
        ST_MEM,
        ST_WB
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- cpu_top.sv
// 16-bit multi-cycle core with on-chip instruction and data RAMs
// fill both RAMs through the load port while idle, then pulse start
// execution begins at address 0; retire_valid marks each finished instruction
// retire_pc is the pc of the next instruction, wb_* mirror the register write

`default_nettype none
`timescale 1ns/10ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_valid,
    input  logic      load_to_data,
    input  mem_addr_t load_addr,
    input  word_t     load_data,
    input  logic      start,
    output logic      busy,
    output logic      retire_valid,
    output mem_addr_t retire_pc,
    output logic      wb_valid,
    output reg_idx_t  wb_reg,
    output word_t     wb_data
);

    // instruction register is the registered imem output
    instr_t     instr;
    mem_addr_t  pc;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    word_t      product;
    word_t      mem_rdata;
    logic       imem_load_we;
    logic       dmem_load_we;
    logic       ram_load_sel;
    logic       dmem_core_we;
    logic       rf_read;
    logic       rf_we;
    logic [1:0] rf_we_src;
    logic       alu_go;
    logic       pc_step;
    logic       pc_clear;
    logic       regs_equal;

    assign retire_pc = pc;
    assign wb_valid  = rf_we;

    cpu_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_valid   (load_valid),
        .load_to_data (load_to_data),
        .start        (start),
        .opcode       (instr.r.opcode),
        .func         (instr.r.func),
        .busy         (busy),
        .imem_load_we (imem_load_we),
        .dmem_load_we (dmem_load_we),
        .ram_load_sel (ram_load_sel),
        .dmem_core_we (dmem_core_we),
        .ir_load      (),
        .rf_read      (rf_read),
        .alu_go       (alu_go),
        .pc_step      (pc_step),
        .pc_clear     (pc_clear),
        .rf_we        (rf_we),
        .rf_we_src    (rf_we_src),
        .retire_valid (retire_valid)
    );

    pc_unit u_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_clear   (pc_clear),
        .pc_step    (pc_step),
        .opcode     (instr.r.opcode),
        .jump_addr  (instr.j.addr),
        .imm        (instr.i.imm),
        .regs_equal (regs_equal),
        .pc         (pc)
    );

    reg_file u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rf_read    (rf_read),
        .rs         (instr.r.rs),
        .rt         (instr.r.rt),
        .rd         (instr.r.rd),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rf_we      (rf_we),
        .rf_we_src  (rf_we_src),
        .alu_result (alu_result),
        .product    (product),
        .mem_rdata  (mem_rdata),
        .wr_idx     (wb_reg),
        .wr_data    (wb_data)
    );

    cpu_alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_go     (alu_go),
        .opcode     (instr.r.opcode),
        .func       (instr.r.func),
        .imm        (instr.i.imm),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_result (alu_result),
        .product    (product),
        .regs_equal (regs_equal)
    );

    word_ram #(.payload_t(instr_t)) u_imem (
        .clk       (clk),
        .load_sel  (ram_load_sel),
        .load_we   (imem_load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .core_we   (1'b0),
        .core_addr (pc),
        .core_data ('0),
        .rdata     (instr)
    );

    // data address is rs+imm taken mod 128
    word_ram #(.payload_t(word_t)) u_dmem (
        .clk       (clk),
        .load_sel  (ram_load_sel),
        .load_we   (dmem_load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .core_we   (dmem_core_we),
        .core_addr (alu_result[PC_W-1:0]),
        .core_data (rt_data),
        .rdata     (mem_rdata)
    );

endmodule

`default_nettype wire

//--- pc_unit.sv
// program counter, word addressed, all arithmetic wraps mod 128
// jump takes bits 7 to 1 of the 13-bit address field

`default_nettype none
`timescale 1ns/10ps

module pc_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pc_clear,
    input  logic              pc_step,
    input  opcode_e           opcode,
    input  logic [12:0]       jump_addr,
    input  logic signed [4:0] imm,
    input  logic              regs_equal,
    output mem_addr_t         pc
);

    mem_addr_t pc_inc;

    assign pc_inc = pc + mem_addr_t'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_clear) begin
            pc <= '0;
        end else if (pc_step) begin
            case (opcode)
                OP_JUMP: pc <= jump_addr[PC_W:1];
                // branch offset is relative to pc+1
                OP_BEQ:  pc <= regs_equal ? pc_inc + mem_addr_t'(imm) : pc_inc;
                default: pc <= pc_inc;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
// sixteen signed registers, r0 is ordinary and writable
// operands are latched on rf_read and hold until the next read
// the write-back mux sits here; load writes rt, the rest write rd

`default_nettype none
`timescale 1ns/10ps

module reg_file
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rf_read,
    input  reg_idx_t   rs,
    input  reg_idx_t   rt,
    input  reg_idx_t   rd,
    output word_t      rs_data,
    output word_t      rt_data,
    input  logic       rf_we,
    input  logic [1:0] rf_we_src,
    input  word_t      alu_result,
    input  word_t      product,
    input  word_t      mem_rdata,
    output reg_idx_t   wr_idx,
    output word_t      wr_data
);

    word_t regs [REG_COUNT];

    assign wr_idx = (rf_we_src == WB_SRC_MEM) ? rt : rd;

    always_comb begin
        case (rf_we_src)
            WB_SRC_MULT: wr_data = product;
            WB_SRC_MEM:  wr_data = mem_rdata;
            default:     wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // operand latch for EXEC
    always_ff @(posedge clk) begin
        if (rf_read) begin
            rs_data <= regs[rs];
            rt_data <= regs[rt];
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# run from the project root; exits 1 on a build error or a failing test
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_cpu -f all.f -o sim_cpu \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 ; cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; } || exit 0

//--- tb_cpu.sv
// random program and data test of cpu_top against a behavioural model
// only the order of retire events is checked, not the cycle counts
// opcodes 6 and 7 are never generated; self loops are broken up at generation

`default_nettype none
`timescale 1ns/10ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int NUM_RETIRE  = 400;
    localparam int LOAD_CYCLES = 2 * MEM_DEPTH;
    localparam int MAX_CYCLES  = 8 + LOAD_CYCLES + NUM_RETIRE * 5 + 100;

    logic      clk;
    logic      rst_n;
    logic      load_valid;
    logic      load_to_data;
    mem_addr_t load_addr;
    word_t     load_data;
    logic      start;
    logic      busy;
    logic      retire_valid;
    mem_addr_t retire_pc;
    logic      wb_valid;
    reg_idx_t  wb_reg;
    word_t     wb_data;

    // reference model state
    logic [15:0] imem_model [MEM_DEPTH];
    word_t       dmem_model [MEM_DEPTH];
    word_t       regs_model [REG_COUNT];
    mem_addr_t   pc_model;

    int   value_errors;
    int   protocol_errors;
    int   retired;
    int   cycles;
    int   op_count [8];
    logic started;

    cpu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_valid   (load_valid),
        .load_to_data (load_to_data),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start        (start),
        .busy         (busy),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ########################################################################
    // compare tasks
    // ########################################################################
    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got r%0d expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input mem_addr_t got, input mem_addr_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wb_presence(input logic got, input logic exp, input mem_addr_t at_pc);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: wb_valid is %b for instruction at %0d, expected %b",
                     $time, got, at_pc, exp);
        end
    endtask

    // ########################################################################
    // stimulus generation
    // ########################################################################
    // half the picks come from r0..r3 so beq and load/store pairs collide
    function automatic reg_idx_t pick_reg();
        if ($urandom_range(0, 1) == 0) begin
            return reg_idx_t'($urandom_range(0, 3));
        end
        return reg_idx_t'($urandom_range(0, 15));
    endfunction

    function automatic logic [15:0] random_instr(input int idx);
        logic [2:0]  op;
        logic [15:0] ins;
        op  = 3'($urandom_range(0, 5));
        ins = {op, pick_reg(), pick_reg(), pick_reg(), 1'($urandom_range(0, 1))};
        if (op == 3'd4) begin
            ins[12:0] = 13'($urandom);
            // no jump to itself
            if (ins[7:1] == 7'(idx)) begin
                ins[1] = ~ins[1];
            end
        end
        // beq with offset -1 would spin forever on a taken branch
        if (op == 3'd5 && ins[4:0] == 5'h1f) begin
            ins[4:0] = 5'h01;
        end
        return ins;
    endfunction

    // ########################################################################
    // model step once per retire
    // ########################################################################
    task automatic step_model();
        logic [15:0]       ins;
        logic [2:0]        op;
        logic              func;
        logic signed [4:0] imm;
        word_t             a;
        word_t             b;
        word_t             exp_data;
        logic              exp_wb;
        reg_idx_t          exp_reg;
        mem_addr_t         next_pc;
        mem_addr_t         addr;
        int                prod;
        ins      = imem_model[pc_model];
        op       = ins[15:13];
        func     = ins[0];
        imm      = ins[4:0];
        a        = regs_model[ins[12:9]];
        b        = regs_model[ins[8:5]];
        addr     = mem_addr_t'(int'(a) + int'(imm));
        exp_wb   = 1'b0;
        exp_reg  = ins[4:1];
        exp_data = '0;
        next_pc  = pc_model + 7'd1;
        op_count[op]++;
        case (op)
            3'd0: begin
                exp_wb   = 1'b1;
                exp_data = func ? word_t'(int'(a) + int'(b)) : word_t'(int'(a) - int'(b));
            end
            3'd1: begin
                exp_wb = 1'b1;
                prod   = int'(a) * int'(b);
                if (func) begin
                    exp_data = (int'(a) < int'(b)) ? word_t'(1) : word_t'(0);
                end else begin
                    exp_data = word_t'(prod[15:0]);
                end
            end
            3'd2: dmem_model[addr] = b;
            3'd3: begin
                exp_wb   = 1'b1;
                exp_reg  = ins[8:5];
                exp_data = dmem_model[addr];
            end
            3'd4: next_pc = ins[7:1];
            3'd5: begin
                if (a == b) begin
                    next_pc = mem_addr_t'(int'(pc_model) + 1 + int'(imm));
                end
            end
            default: ;
        endcase
        wb_presence(wb_valid, exp_wb, pc_model);
        if (exp_wb) begin
            check_reg(wb_reg, exp_reg, "wb_reg");
            check_word(wb_data, exp_data, "wb_data");
            regs_model[exp_reg] = exp_data;
        end
        check_pc(retire_pc, next_pc, "retire_pc");
        pc_model = next_pc;
    endtask

    // output checks and model step on the falling edge
    always @(negedge clk) begin
        if (!started && (busy || retire_valid)) begin
            protocol_errors++;
            $display("busy or retire_valid went high before start at %0t", $time);
        end
        if (wb_valid && !retire_valid) begin
            protocol_errors++;
            $display("wb_valid high without retire_valid at %0t", $time);
        end
        if (retired > 0 && !busy) begin
            protocol_errors++;
            $display("busy dropped while the core was running at %0t", $time);
        end
        if (rst_n && retire_valid) begin
            step_model();
            retired++;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                     retired, NUM_RETIRE, cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ########################################################################
    // main sequence
    // ########################################################################
    initial begin
        void'($urandom(32'hdcd78acb));
        rst_n           = 1'b0;
        load_valid      = 1'b0;
        load_to_data    = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        start           = 1'b0;
        started         = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        retired         = 0;
        cycles          = 0;
        pc_model        = '0;
        for (int i = 0; i < 8; i++) begin
            op_count[i] = 0;
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            regs_model[i] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem_model[i] = random_instr(i);
            dmem_model[i] = word_t'($urandom);
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // fill both RAMs while idle
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            load_valid   <= 1'b1;
            load_to_data <= 1'b0;
            load_addr    <= mem_addr_t'(i);
            load_data    <= imem_model[i];
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            load_valid   <= 1'b1;
            load_to_data <= 1'b1;
            load_addr    <= mem_addr_t'(i);
            load_data    <= dmem_model[i];
        end
        @(posedge clk);
        load_valid <= 1'b0;
        @(posedge clk);
        start   <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        wait (retired >= NUM_RETIRE);
        $display("retired %0d: add/sub %0d, mult/slt %0d, store %0d, load %0d, jump %0d, beq %0d",
                 retired, op_count[0], op_count[1], op_count[2], op_count[3],
                 op_count[4], op_count[5]);
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- word_ram.sv
// single-port synchronous RAM of MEM_DEPTH words, read latency one cycle
// load_sel hands address, data and write enable to the load side
// read-before-write on the same address; contents are not reset

`default_nettype none
`timescale 1ns/10ps

module word_ram
    import cpu_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic      clk,
    input  logic      load_sel,
    input  logic      load_we,
    input  mem_addr_t load_addr,
    input  payload_t  load_data,
    input  logic      core_we,
    input  mem_addr_t core_addr,
    input  payload_t  core_data,
    output payload_t  rdata
);

    payload_t  mem [MEM_DEPTH];
    mem_addr_t addr;
    payload_t  wdata;
    logic      we;

    assign addr  = load_sel ? load_addr : core_addr;
    assign wdata = load_sel ? load_data : core_data;
    assign we    = load_sel ? load_we : core_we;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire
